//--- Bender.yml
package:
  name: astro_input

sources:
  - include_dirs:
      - common
    files:
      - common/astro_pkg.sv
      - common/astro_ifs.sv
      - source/game_config.sv
      - source/paddle_front.sv
      - source/axis_mapper.sv
      - switch_matrix/switch_matrix.sv
      - source/astro_input_top.sv

  - target: test
    include_dirs:
      - common
      - tests
    files:
      - tests/tb_astro_input.sv

//--- common/astro_consts.svh
/*
 * Player-input constants: axis count, paddle centre, row idle value and column codes
 */
`ifndef ASTRO_CONSTS_SVH
`define ASTRO_CONSTS_SVH

// Two sticks with two axes each
`define ASTRO_NUM_AXES 4

// Offset that moves a signed stick byte to an unsigned paddle
`define ASTRO_PADDLE_CENTRE 8'd128

// Row value for unused columns and when no game is selected
`define ASTRO_ROW_IDLE 8'hFF

// One-hot column select codes driven by the game CPU
`define ASTRO_COL_0 8'h01
`define ASTRO_COL_1 8'h02
`define ASTRO_COL_2 8'h04
`define ASTRO_COL_3 8'h08

// DIP switch bytes held by the config block
`define ASTRO_NUM_DIPS 4

// Game numbers as written by the host
`define ASTRO_GAME_NUM_EB  8'd1
`define ASTRO_GAME_NUM_SZ  8'd3
`define ASTRO_GAME_NUM_WOW 8'd5
`define ASTRO_GAME_NUM_RR  8'd6

`endif

//--- common/astro_ifs.sv
/*
 * Axis result and game configuration interfaces of the input subsystem
 */

// ==========================================================================
// One mapped analog axis
// ==========================================================================
interface axis_if;

	// Trackball delta for Extra Bases
	astro_pkg::delta_t delta;
	// Wizard of Wor digital view of the axis
	// neg is left or down, pos is right or up
	logic dir_neg;
	logic dir_pos;
	// Stick pushed near an end stop
	logic move;

	// Mapper produces the result
	modport mapper (
		output delta,
		output dir_neg,
		output dir_pos,
		output move
	);

	// Switch matrix consumes it
	modport matrix (
		input delta,
		input dir_neg,
		input dir_pos,
		input move
	);

endinterface

// ==========================================================================
// Game configuration
// ==========================================================================
interface cfg_if;

	astro_pkg::game_e game;
	// DIP byte 1 is not read by any column
	logic [7:0] dip0;
	logic [7:0] dip2;
	logic [7:0] dip3;

	modport source (output game, output dip0, output dip2, output dip3);
	modport sink (input game, input dip0, input dip2, input dip3);

endinterface

//--- common/astro_pkg.sv
/*
 * Player-input type package for the Astrocade-family arcade board
 */
package astro_pkg;

	// ======================================================================
	// Game selection
	// ======================================================================

	// Games kept on this board
	// Game numbers 1, 3, 5 and 6 select them, any other number gives none
	typedef enum logic [2:0] {
		GAME_NONE          = 3'd0,
		GAME_EXTRA_BASES   = 3'd1,
		GAME_SPACE_ZAP     = 3'd2,
		GAME_WIZARD_OF_WOR = 3'd3,
		GAME_ROBBY_ROTO    = 3'd4
	} game_e;

	// ======================================================================
	// Analog axis payloads
	// ======================================================================

	// Centred paddle position
	// 0 is full negative deflection, 128 is rest, 255 is full positive
	typedef logic [7:0] paddle_t;

	// Trackball delta as the CPU reads it in column 08
	// Two's complement, range -8 to +7 in practice
	typedef logic signed [7:0] delta_t;

endpackage

//--- flist.f
+incdir+common
+incdir+tests
common/astro_pkg.sv
common/astro_ifs.sv
source/game_config.sv
source/paddle_front.sv
source/axis_mapper.sv
switch_matrix/switch_matrix.sv
source/astro_input_top.sv
tests/tb_astro_input.sv

//--- source/astro_input_top.sv
/*
 * Player-input subsystem top: config, analog front end, axis mappers and switch matrix
 */
`include "astro_consts.svh"

module astro_input_top (
	input  logic        i_clk_sys,
	input  logic        i_reset,
	input  logic        i_game_wr,
	input  logic [7:0]  i_game_num,
	input  logic        i_dip_wr,
	input  logic [1:0]  i_dip_addr,
	input  logic [7:0]  i_dip_data,
	input  logic [15:0] i_joy0,
	input  logic [15:0] i_joy1,
	input  logic [15:0] i_joy_a0,
	input  logic [15:0] i_joy_a1,
	input  logic [7:0]  i_col_select,
	input  logic [1:0]  i_track_select,
	output logic [7:0]  o_row_data
);

	astro_pkg::paddle_t [`ASTRO_NUM_AXES-1:0] paddle;

	cfg_if  cfg_bus ();
	axis_if axis_bus [`ASTRO_NUM_AXES] ();

	game_config u_game_config (
		.i_clk_sys  (i_clk_sys),
		.i_reset    (i_reset),
		.i_game_wr  (i_game_wr),
		.i_game_num (i_game_num),
		.i_dip_wr   (i_dip_wr),
		.i_dip_addr (i_dip_addr),
		.i_dip_data (i_dip_data),
		.o_cfg      (cfg_bus)
	);

	paddle_front u_paddle_front (
		.i_clk_sys (i_clk_sys),
		.i_reset   (i_reset),
		.i_joy_a0  (i_joy_a0),
		.i_joy_a1  (i_joy_a1),
		.o_paddle  (paddle)
	);

	// One mapper per paddle axis
	for (genvar g = 0; g < `ASTRO_NUM_AXES; g++) begin : g_mapper
		axis_mapper u_axis_mapper (
			.i_clk_sys (i_clk_sys),
			.i_reset   (i_reset),
			.i_paddle  (paddle[g]),
			.o_axis    (axis_bus[g])
		);
	end

	switch_matrix u_switch_matrix (
		.i_clk_sys      (i_clk_sys),
		.i_reset        (i_reset),
		.i_cfg          (cfg_bus),
		.i_axis         (axis_bus),
		.i_joy0         (i_joy0),
		.i_joy1         (i_joy1),
		.i_col_select   (i_col_select),
		.i_track_select (i_track_select),
		.o_row_data     (o_row_data)
	);

endmodule

//--- source/axis_mapper.sv
/*
 * Axis mapper turning one paddle into a trackball delta and Wizard of Wor direction/move bits
 */
module axis_mapper (
	input  logic               i_clk_sys,
	input  logic               i_reset,
	input  astro_pkg::paddle_t i_paddle,
	axis_if.mapper             o_axis
);

	// Top nibble minus 8 in five signed bits
	logic signed [4:0] nib_ofs;
	astro_pkg::delta_t delta_d;
	logic              dir_neg_d;
	logic              dir_pos_d;
	logic              move_d;

	// Sixteen delta steps across the stick travel with zero at rest
	assign nib_ofs = $signed({1'b0, i_paddle[7:4]}) - 5'sd8;
	assign delta_d = {{3{nib_ofs[4]}}, nib_ofs};

	// Eight coarse zones from the top three bits
	// Outer zones also press move and the middle four are dead
	always_comb begin
		dir_neg_d = 1'b0;
		dir_pos_d = 1'b0;
		move_d    = 1'b0;
		case (i_paddle[7:5])
			3'd0: begin
				dir_neg_d = 1'b1;
				move_d    = 1'b1;
			end
			3'd1: dir_neg_d = 1'b1;
			3'd6: dir_pos_d = 1'b1;
			3'd7: begin
				dir_pos_d = 1'b1;
				move_d    = 1'b1;
			end
			default: ;
		endcase
	end

	// Registered result with the reset value of a centred stick
	always_ff @(posedge i_clk_sys or posedge i_reset) begin
		if (i_reset) begin
			o_axis.delta   <= '0;
			o_axis.dir_neg <= 1'b0;
			o_axis.dir_pos <= 1'b0;
			o_axis.move    <= 1'b0;
		end else begin
			o_axis.delta   <= delta_d;
			o_axis.dir_neg <= dir_neg_d;
			o_axis.dir_pos <= dir_pos_d;
			o_axis.move    <= move_d;
		end
	end

	// A direction bit needs a delta of the same sign and so never pairs with its opposite
	a_dir_exclusive: assert property (
		@(posedge i_clk_sys) disable iff (i_reset)
		(!o_axis.dir_neg || o_axis.delta < -8'sd4) && (!o_axis.dir_pos || o_axis.delta > 8'sd3)
	);

endmodule

//--- source/game_config.sv
/*
 * Game configuration: game number latch with one-hot decode and the DIP byte bank
 */
`include "astro_consts.svh"

module game_config (
	input  logic       i_clk_sys,
	input  logic       i_reset,
	input  logic       i_game_wr,
	input  logic [7:0] i_game_num,
	input  logic       i_dip_wr,
	input  logic [1:0] i_dip_addr,
	input  logic [7:0] i_dip_data,
	cfg_if.source      o_cfg
);

	// Raw game number from the host
	logic [7:0]       game_num_q;
	// Decoded game, one cycle behind the number
	astro_pkg::game_e game_q;
	// DIP bank, all switches off after reset
	logic [7:0]       dip_q [`ASTRO_NUM_DIPS];

	// ======================================================================
	// Game number latch and decode
	// ======================================================================
	always_ff @(posedge i_clk_sys or posedge i_reset) begin
		if (i_reset) begin
			game_num_q <= 8'd0;
			game_q     <= astro_pkg::GAME_NONE;
		end else begin
			// One-cycle strobe loads the number
			if (i_game_wr) begin
				game_num_q <= i_game_num;
			end
			// Decode follows on the next edge
			case (game_num_q)
				`ASTRO_GAME_NUM_EB:  game_q <= astro_pkg::GAME_EXTRA_BASES;
				`ASTRO_GAME_NUM_SZ:  game_q <= astro_pkg::GAME_SPACE_ZAP;
				`ASTRO_GAME_NUM_WOW: game_q <= astro_pkg::GAME_WIZARD_OF_WOR;
				`ASTRO_GAME_NUM_RR:  game_q <= astro_pkg::GAME_ROBBY_ROTO;
				// Unknown numbers and the dropped games land here
				default:             game_q <= astro_pkg::GAME_NONE;
			endcase
		end
	end

	// ======================================================================
	// DIP switch bytes
	// ======================================================================
	always_ff @(posedge i_clk_sys or posedge i_reset) begin
		if (i_reset) begin
			for (int i = 0; i < `ASTRO_NUM_DIPS; i++) begin
				dip_q[i] <= 8'hFF;
			end
		end else if (i_dip_wr) begin
			dip_q[i_dip_addr] <= i_dip_data;
		end
	end

	// Config out to the matrix
	assign o_cfg.game = game_q;
	assign o_cfg.dip0 = dip_q[0];
	assign o_cfg.dip2 = dip_q[2];
	assign o_cfg.dip3 = dip_q[3];

	// A DIP write must carry a clean address
	a_dip_addr_known: assert property (
		@(posedge i_clk_sys) disable iff (i_reset)
		i_dip_wr |-> !$isunknown(i_dip_addr)
	);

endmodule

//--- source/paddle_front.sv
/*
 * Analog front end: two stick words to four registered, centred paddle axes
 */
`include "astro_consts.svh"

module paddle_front (
	input  logic                                        i_clk_sys,
	input  logic                                        i_reset,
	input  logic [15:0]                                 i_joy_a0,
	input  logic [15:0]                                 i_joy_a1,
	output astro_pkg::paddle_t [`ASTRO_NUM_AXES-1:0]    o_paddle
);

	// Signed stick bytes before the centre offset
	logic [`ASTRO_NUM_AXES-1:0][7:0] stick_raw;

	// ======================================================================
	// Axis order
	// ======================================================================
	// Axis 0 is P1 left/right, low byte of stick 0
	assign stick_raw[0] = i_joy_a0[7:0];
	// Axis 1 is P1 up/down
	// Stick reports up as negative, the cabinet wants it positive
	assign stick_raw[1] = ~i_joy_a0[15:8];
	// Axes 2 and 3 repeat the layout for stick 1
	assign stick_raw[2] = i_joy_a1[7:0];
	assign stick_raw[3] = ~i_joy_a1[15:8];

	// ======================================================================
	// Centre and register
	// ======================================================================
	always_ff @(posedge i_clk_sys or posedge i_reset) begin
		if (i_reset) begin
			// Sticks at rest
			for (int i = 0; i < `ASTRO_NUM_AXES; i++) begin
				o_paddle[i] <= `ASTRO_PADDLE_CENTRE;
			end
		end else begin
			// Adding 128 modulo 256 turns -128..127 into 0..255
			for (int i = 0; i < `ASTRO_NUM_AXES; i++) begin
				o_paddle[i] <= stick_raw[i] + `ASTRO_PADDLE_CENTRE;
			end
		end
	end

endmodule

//--- switch_matrix/switch_matrix.sv
/*
 * Switch matrix: per-game column bytes selected by the CPU column and trackball select
 */
`include "astro_consts.svh"

module switch_matrix (
	input  logic        i_clk_sys,
	input  logic        i_reset,
	cfg_if.sink         i_cfg,
	axis_if.matrix      i_axis [`ASTRO_NUM_AXES],
	input  logic [15:0] i_joy0,
	input  logic [15:0] i_joy1,
	input  logic [7:0]  i_col_select,
	input  logic [1:0]  i_track_select,
	output logic [7:0]  o_row_data
);

	// Axis results flattened out of the interface array
	astro_pkg::delta_t               axis_delta [`ASTRO_NUM_AXES];
	logic [`ASTRO_NUM_AXES-1:0]      axis_neg;
	logic [`ASTRO_NUM_AXES-1:0]      axis_pos;
	logic [`ASTRO_NUM_AXES-1:0]      axis_move;
	logic                            is_eb;
	logic                            is_wow;
	logic [7:0]                      eb_col0;
	logic [7:0]                      eb_col1;
	logic [7:0]                      std_col0;
	logic [7:0]                      p1_stick;
	logic [7:0]                      p2_stick;
	logic [7:0]                      track_delta;
	logic [7:0]                      row_d;

	for (genvar a = 0; a < `ASTRO_NUM_AXES; a++) begin : g_axis
		assign axis_delta[a] = i_axis[a].delta;
		assign axis_neg[a]   = i_axis[a].dir_neg;
		assign axis_pos[a]   = i_axis[a].dir_pos;
		assign axis_move[a]  = i_axis[a].move;
	end

	// Stick byte: 1, 1, ~fire, move, ~right, ~left, ~down, ~up
	// Joystick word bits: right 0, left 1, down 2, up 3, fire 4, move 5
	function automatic logic [7:0] stick_byte(
		input logic [15:0] joy,
		input logic        wow,
		input logic        analog,
		input logic        lr_neg,
		input logic        lr_pos,
		input logic        ud_neg,
		input logic        ud_pos,
		input logic        any_move
	);
		logic [3:0] dir_n;
		logic       move_bit;
		if (wow && analog) begin
			// Directions from the mappers, move when either axis is at a stop
			dir_n    = {~lr_pos, ~lr_neg, ~ud_neg, ~ud_pos};
			move_bit = ~any_move;
		end else begin
			dir_n    = {~joy[0], ~joy[1], ~joy[2], ~joy[3]};
			// Only Wizard of Wor has a move button, active high
			move_bit = wow ? joy[5] : 1'b1;
		end
		return {2'b11, ~joy[4], move_bit, dir_n};
	endfunction

	assign is_eb  = (i_cfg.game == astro_pkg::GAME_EXTRA_BASES);
	assign is_wow = (i_cfg.game == astro_pkg::GAME_WIZARD_OF_WOR);

	// ======================================================================
	// Column bytes
	// ======================================================================
	// Extra Bases: starts and both fire buttons
	assign eb_col0 = {2'b11, ~i_joy0[7], ~i_joy0[6], 2'b11, ~i_joy0[4], ~i_joy1[4]};
	// Extra Bases: two jumpers share dip0 bit 1, coin at bit 0
	assign eb_col1 = {1'b1, i_cfg.dip0[1], 1'b1, i_cfg.dip0[1], 3'b111, ~i_joy0[8]};
	// Other games: starts, coin and two dip2 switches
	assign std_col0 = {i_cfg.dip2[2], ~i_joy0[7], ~i_joy0[6], 1'b1,
		i_cfg.dip2[1], 1'b1, ~i_joy0[8], 1'b1};

	// P1 uses axes 0 and 1, analog mode on dip0 bit 0
	assign p1_stick = stick_byte(i_joy0, is_wow, i_cfg.dip0[0], axis_neg[0], axis_pos[0],
		axis_neg[1], axis_pos[1], axis_move[0] | axis_move[1]);
	// P2 uses axes 2 and 3, analog mode on dip0 bit 1
	assign p2_stick = stick_byte(i_joy1, is_wow, i_cfg.dip0[1], axis_neg[2], axis_pos[2],
		axis_neg[3], axis_pos[3], axis_move[2] | axis_move[3]);

	// Trackball axis picked by the CPU
	always_comb begin
		case (i_track_select)
			2'd0:    track_delta = axis_delta[1];
			2'd1:    track_delta = axis_delta[0];
			2'd2:    track_delta = axis_delta[3];
			default: track_delta = axis_delta[2];
		endcase
	end

	// ======================================================================
	// Column select and row register
	// ======================================================================
	always_comb begin
		row_d = `ASTRO_ROW_IDLE;
		if (i_cfg.game != astro_pkg::GAME_NONE) begin
			case (i_col_select)
				`ASTRO_COL_0: row_d = is_eb ? eb_col0 : std_col0;
				`ASTRO_COL_1: row_d = is_eb ? eb_col1 : p2_stick;
				`ASTRO_COL_2: row_d = is_eb ? i_cfg.dip2 : p1_stick;
				`ASTRO_COL_3: row_d = is_eb ? track_delta : i_cfg.dip3;
				default:      row_d = `ASTRO_ROW_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk_sys or posedge i_reset) begin
		if (i_reset) begin
			o_row_data <= `ASTRO_ROW_IDLE;
		end else begin
			o_row_data <= row_d;
		end
	end

	// No game selected means an idle row on the next read
	a_idle_without_game: assert property (
		@(posedge i_clk_sys) disable iff (i_reset)
		(i_cfg.game == astro_pkg::GAME_NONE) |=> (o_row_data == `ASTRO_ROW_IDLE)
	);

endmodule

//--- tests/tb_astro_ref.svh
/*
 * Reference model of the player-input rules: paddle centring, axis mapping and column bytes
 */
`ifndef TB_ASTRO_REF_SVH
`define TB_ASTRO_REF_SVH

`include "astro_consts.svh"

// Stick byte plus centre, up/down bytes are inverted first
function automatic logic [7:0] ref_paddle(input logic [7:0] raw, input logic invert);
	logic [7:0] b;
	b = invert ? ~raw : raw;
	return b + `ASTRO_PADDLE_CENTRE;
endfunction

// Top nibble less 8, sign-extended
function automatic logic [7:0] ref_delta(input logic [7:0] pad);
	int d;
	d = int'(pad[7:4]) - 8;
	return d[7:0];
endfunction

// Zone decode as {dir_neg, dir_pos, move}
function automatic logic [2:0] ref_dir(input logic [7:0] pad);
	case (pad[7:5])
		3'd0:    return 3'b101;
		3'd1:    return 3'b100;
		3'd6:    return 3'b010;
		3'd7:    return 3'b011;
		default: return 3'b000;
	endcase
endfunction

// Expected row for a game number, column and track select
function automatic logic [7:0] ref_row(input int unsigned game, input logic [7:0] col,
	input logic [1:0] trk, input logic [15:0] joy0, input logic [15:0] joy1,
	input logic [15:0] ana0, input logic [15:0] ana1,
	input logic [7:0] dip0, input logic [7:0] dip2, input logic [7:0] dip3);
	logic [7:0]  pad [4];
	logic [7:0]  stick [2];
	logic [15:0] joy;
	logic [2:0]  lr;
	logic [2:0]  ud;
	int          tix;
	pad[0] = ref_paddle(ana0[7:0], 1'b0);
	pad[1] = ref_paddle(ana0[15:8], 1'b1);
	pad[2] = ref_paddle(ana1[7:0], 1'b0);
	pad[3] = ref_paddle(ana1[15:8], 1'b1);
	// Index 0 is P1 on column 04, index 1 is P2 on column 02
	for (int p = 0; p < 2; p++) begin
		joy = (p == 0) ? joy0 : joy1;
		lr = ref_dir(pad[2 * p]);
		ud = ref_dir(pad[2 * p + 1]);
		stick[p] = {2'b11, ~joy[4], 1'b1, ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
		if (game == 5 && dip0[p]) begin
			// Right, left, down, up from the mapper zones
			stick[p][3:0] = {~lr[1], ~lr[2], ~ud[2], ~ud[1]};
			stick[p][4] = ~(lr[0] | ud[0]);
		end else if (game == 5) begin
			stick[p][4] = joy[5];
		end
	end
	// Track select 0..3 picks P1 up/down, P1 left/right, P2 up/down, P2 left/right
	tix = (trk == 2'd0) ? 1 : (trk == 2'd1) ? 0 : (trk == 2'd2) ? 3 : 2;
	if (game == 1) begin
		case (col)
			8'h01:   return {2'b11, ~joy0[7], ~joy0[6], 2'b11, ~joy0[4], ~joy1[4]};
			8'h02:   return {1'b1, dip0[1], 1'b1, dip0[1], 3'b111, ~joy0[8]};
			8'h04:   return dip2;
			8'h08:   return ref_delta(pad[tix]);
			default: return 8'hFF;
		endcase
	end else if (game == 3 || game == 5 || game == 6) begin
		case (col)
			8'h01:   return {dip2[2], ~joy0[7], ~joy0[6], 1'b1, dip2[1], 1'b1, ~joy0[8], 1'b1};
			8'h02:   return stick[1];
			8'h04:   return stick[0];
			8'h08:   return dip3;
			default: return 8'hFF;
		endcase
	end
	return 8'hFF;
endfunction

`endif

//--- tests/tb_astro_input.sv
/*
 * Player-input subsystem testbench with random stimulus checked against a reference model
 */
`include "astro_consts.svh"

module tb_astro_input;
	timeunit 1ns;
	timeprecision 1ps;

	`include "tb_astro_ref.svh"

	localparam int RESET_CYCLES = 8;
	// Longest path is analog to row plus two cycles of margin
	localparam int SETTLE = 3 + 2;
	// Cycles of each test from its writes, one settle per checked column and the closing edge
	localparam int T1_CYCLES = 8 * SETTLE + 1;
	localparam int T2_CYCLES = 1 + 8 * (2 + 2 * SETTLE) + 1;
	localparam int T3_CYCLES = 16 * (1 + 2 * SETTLE) + 1;
	localparam int T4_CYCLES = 1 + 8 * 4 * SETTLE + 1;
	localparam int T5_CYCLES = 1 + 16 * (1 + 2 * SETTLE) + 1;
	localparam int T6_CYCLES = 4 * (2 + 4 * SETTLE) + 1;
	localparam int RUN_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
		+ T4_CYCLES + T5_CYCLES + T6_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

	logic        clk_sys;
	logic        reset;
	logic        i_game_wr;
	logic        i_dip_wr;
	logic [7:0]  i_game_num;
	logic [7:0]  i_dip_data;
	logic [7:0]  i_col_select;
	logic [7:0]  o_row_data;
	logic [1:0]  i_dip_addr;
	logic [1:0]  i_track_select;
	logic [15:0] i_joy0;
	logic [15:0] i_joy1;
	logic [15:0] i_joy_a0;
	logic [15:0] i_joy_a1;

	// Model state
	int unsigned m_game;
	logic [7:0]  m_dip [4];
	logic [7:0]  exp_row;
	logic [7:0]  chk_col;
	int          pass_count;
	int          fail_count;
	int          test_checks;
	int          test_errs;
	int          cycle_count;
	int unsigned known_games [4] = '{1, 3, 5, 6};
	event        compare_ev;

	astro_input_top u_dut (
		.i_clk_sys      (clk_sys),
		.i_reset        (reset),
		.i_game_wr      (i_game_wr),
		.i_game_num     (i_game_num),
		.i_dip_wr       (i_dip_wr),
		.i_dip_addr     (i_dip_addr),
		.i_dip_data     (i_dip_data),
		.i_joy0         (i_joy0),
		.i_joy1         (i_joy1),
		.i_joy_a0       (i_joy_a0),
		.i_joy_a1       (i_joy_a1),
		.i_col_select   (i_col_select),
		.i_track_select (i_track_select),
		.o_row_data     (o_row_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// =====================================================================
	// Stimulus tasks are entered and left on a falling edge
	// =====================================================================
	task automatic write_game(input logic [7:0] num);
		i_game_wr = 1'b1;
		i_game_num = num;
		m_game = num;
		@(negedge clk_sys);
		i_game_wr = 1'b0;
	endtask

	task automatic write_dip(input logic [1:0] addr, input logic [7:0] data);
		i_dip_wr = 1'b1;
		i_dip_addr = addr;
		i_dip_data = data;
		m_dip[addr] = data;
		@(negedge clk_sys);
		i_dip_wr = 1'b0;
	endtask

	task automatic randomize_sticks();
		i_joy0 = 16'($urandom);
		i_joy1 = 16'($urandom);
		i_joy_a0 = 16'($urandom);
		i_joy_a1 = 16'($urandom);
	endtask

	// Select a column, let the pipeline settle, then hand over to the compare process
	task automatic check_col(input logic [7:0] col, input logic [1:0] trk);
		i_col_select = col;
		i_track_select = trk;
		repeat (SETTLE) @(negedge clk_sys);
		exp_row = ref_row(m_game, col, trk, i_joy0, i_joy1, i_joy_a0, i_joy_a1,
			m_dip[0], m_dip[2], m_dip[3]);
		chk_col = col;
		-> compare_ev;
	endtask

	task automatic finish_test(input int num, input string name);
		@(negedge clk_sys);
		$display("Test %0d %s: %0d checks, %0d errors", num, name, test_checks, test_errs);
		test_checks = 0;
		test_errs = 0;
	endtask

	// Any number outside the four kept games
	function automatic logic [7:0] unknown_game_num();
		logic [7:0] n;
		do begin
			n = 8'($urandom);
		end while (n == 1 || n == 3 || n == 5 || n == 6);
		return n;
	endfunction

	// Compare process
	always @(compare_ev) begin
		test_checks++;
		assert (o_row_data === exp_row) begin
			pass_count++;
		end else begin
			$display("Error at time %0t: o_row_data expected %02h, actual %02h (column %02h)",
				$time, exp_row, o_row_data, chk_col);
			fail_count++;
			test_errs++;
		end
	end

	// Run limit
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// =====================================================================
	// Test sequence
	// =====================================================================
	initial begin
		void'($urandom(32'h970b7fff));
		{pass_count, fail_count, test_checks, test_errs} = '0;
		reset = 1'b1;
		{i_game_wr, i_dip_wr, i_game_num, i_dip_addr, i_dip_data} = '0;
		{i_joy0, i_joy1, i_joy_a0, i_joy_a1, i_col_select, i_track_select} = '0;
		m_game = 0;
		for (int i = 0; i < 4; i++) begin
			m_dip[i] = 8'hFF;
		end
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset = 1'b0;

		// Idle rows on every column bit with no game
		for (int k = 0; k < 8; k++) begin
			randomize_sticks();
			check_col(8'h01 << k, 2'($urandom));
		end
		finish_test(1, "reset state");

		write_game(8'd3);
		for (int k = 0; k < 8; k++) begin
			write_dip(2'd2, 8'($urandom));
			write_dip(2'd3, 8'($urandom));
			randomize_sticks();
			check_col(`ASTRO_COL_3, 2'd0);
			check_col(`ASTRO_COL_0, 2'd0);
		end
		finish_test(2, "DIP columns");

		// Space Zap and Robby Roto in turn
		for (int k = 0; k < 16; k++) begin
			write_game((k % 2 == 0) ? 8'd3 : 8'd6);
			randomize_sticks();
			check_col(`ASTRO_COL_1, 2'd0);
			check_col(`ASTRO_COL_2, 2'd0);
		end
		finish_test(3, "digital sticks");

		write_game(8'd1);
		for (int k = 0; k < 8; k++) begin
			randomize_sticks();
			for (int t = 0; t < 4; t++) begin
				check_col(`ASTRO_COL_3, 2'(t));
			end
		end
		finish_test(4, "trackball deltas");

		// Even steps use mapper directions and odd steps the buttons
		write_game(8'd5);
		for (int k = 0; k < 16; k++) begin
			if (k % 2 == 0) begin
				write_dip(2'd0, 8'($urandom) | 8'h03);
			end else begin
				write_dip(2'd0, 8'($urandom) & 8'hFC);
			end
			randomize_sticks();
			check_col(`ASTRO_COL_1, 2'd0);
			check_col(`ASTRO_COL_2, 2'd0);
		end
		finish_test(5, "Wizard of Wor analog mode");

		for (int k = 0; k < 4; k++) begin
			write_game(8'(known_games[$urandom_range(3, 0)]));
			write_game(unknown_game_num());
			for (int c = 0; c < 4; c++) begin
				check_col(8'h01 << c, 2'($urandom));
			end
		end
		finish_test(6, "game switching");

		$display("Summary: %0d checks passed, %0d checks failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
